/* rtl/siggen_regmap_pkg.sv */
// register map of the pattern generator; imported by every RTL module and by the testbench
package siggen_regmap_pkg;

	localparam int reg_count = 22;          // one-byte registers in the file

	// byte addresses
	localparam int pattern_base    = 0;     // pattern bytes 0..7 with bit n in byte n/8
	localparam int rise_ts_addr    = 8;     // rising edge timestamp with the lsb first
	localparam int fall_ts_addr    = 12;    // falling edge timestamp with the lsb first
	localparam int length_addr     = 17;    // pattern length in the low 6 bits where 0 means 64
	localparam int sleep_addr      = 18;    // sleep ticks where 0 means 256
	localparam int divisor_addr    = 19;    // timebase divisor
	localparam int config_addr     = 20;    // flags byte as laid out in siggen_ctrl_pkg
	localparam int trig_count_addr = 21;    // accepted trigger count that wraps at 255

	// byte address on the host port
	typedef logic [4:0] reg_addr_t;

	// whole register file as one packed word with byte i at [i]
	typedef logic [reg_count-1:0][7:0] reg_array_t;

	// one update request bit per register byte
	typedef logic [reg_count-1:0] reg_flags_t;

	// host write strobe valid for one cycle when en is high
	typedef struct packed {
		logic      en;                      // write strobe
		reg_addr_t addr;                    // target byte
		logic [7:0] data;                   // value to store
	} host_wr_t;

	// addresses 22 to 31 of the 32-entry address space lie above reg_count and read as zero
	// byte 16 has no function in the generator and is plain storage for the host

endpackage

/* rtl/siggen_ctrl_pkg.sv */
// control encodings of the generator: modes, FSM states and the config byte layout
package siggen_ctrl_pkg;

	// what happens once a pass is over
	typedef enum logic [1:0] {
		mode_off    = 2'd0,                 // triggers ignored
		mode_single = 2'd1,                 // one pass, then one-shot bits cleared
		mode_multi  = 2'd2,                 // one pass per accepted trigger
		mode_loop   = 2'd3                  // passes repeat back to back
	} loop_mode_t;

	typedef enum logic [1:0] {
		st_idle    = 2'd0,                  // waiting for a trigger edge
		st_pattern = 2'd1,                  // shifting pattern bits
		st_sleep   = 2'd2                   // holding last bit for the sleep time
	} gen_state_t;

	// decoded view of the config byte, msb first
	typedef struct packed {
		logic       save_fall;              // store timestamp on falling trigger
		logic       save_rise;              // store timestamp on rising trigger
		loop_mode_t loop_mode;
		logic       trig_fall;              // falling edge may start a pass
		logic       trig_rise;              // rising edge may start a pass
		logic       div_bypass;             // tick every clk cycle
		logic       enable;
	} sig_cfg_t;

	// same byte seen as register storage or as flags
	typedef union packed {
		logic [7:0] raw;
		sig_cfg_t   cfg;
	} cfg_byte_u;

	localparam logic [7:0] clear_single_mask = 8'b1111_0010; // drop enable and both edges
	localparam logic [7:0] clear_rise_mask   = 8'b1111_1011; // drop trig_rise
	localparam logic [7:0] clear_fall_mask   = 8'b1111_0111; // drop trig_fall

endpackage

/* rtl/timebase.sv */
// timebase of the generator; free-running timestamp and a divided step tick
`timescale 1ns/100ps

module timebase
	import siggen_regmap_pkg::*;
	import siggen_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  reg_array_t  regs,                    // divisor and bypass are read from here
	output logic        tick,                    // one-cycle step strobe
	output logic [31:0] timestamp                // cycles since reset
);

	cfg_byte_u  cfg;                             // config byte, decoded for bypass
	logic [7:0] divisor;
	logic [7:0] div_cnt;                         // cycles left until divided clock toggles
	logic       div_clk;                         // divided clock, half period D+1

	assign cfg.raw = regs[config_addr];
	assign divisor = regs[divisor_addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timestamp <= '0;
			div_cnt   <= '0;
			div_clk   <= 1'b0;
			tick      <= 1'b0;
		end else begin
			timestamp <= timestamp + 32'd1;      // wraps after 2^32 cycles
			if (div_cnt == 8'd0) begin
				div_cnt <= divisor;              // reload, new divisor takes effect here
				div_clk <= ~div_clk;
			end else begin
				div_cnt <= div_cnt - 8'd1;
			end
			// tick marks the cycle in which div_clk has just risen
			tick <= cfg.cfg.div_bypass | ((div_cnt == 8'd0) & ~div_clk);
		end
	end

endmodule

/* rtl/config_regfile.sv */
// byte register file of the generator; host writes, generator write-back and a combinational read
`timescale 1ns/100ps

module config_regfile
	import siggen_regmap_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  host_wr_t   host_wr,                  // one-cycle host write strobe
	input  reg_flags_t upd_flags,                // generator update request per byte
	input  reg_array_t upd_data,                 // generator update value per byte
	input  reg_addr_t  rd_addr,
	output logic [7:0] rd_data,                  // byte at rd_addr, zero past the last one
	output reg_array_t regs                      // whole file to timebase and generator
);

	reg_flags_t host_sel;                        // decoded host write address
	reg_array_t regs_next;

	// address decode, writes beyond reg_count hit nothing
	always_comb begin
		host_sel = '0;
		for (int i = 0; i < reg_count; i++) begin
			host_sel[i] = host_wr.en & (host_wr.addr == reg_addr_t'(i));
		end
	end

	// generator has priority over the host on the same byte
	always_comb begin
		regs_next = regs;
		for (int i = 0; i < reg_count; i++) begin
			if (upd_flags[i]) begin
				regs_next[i] = upd_data[i];      // timestamp, count or cleared config
			end else if (host_sel[i]) begin
				regs_next[i] = host_wr.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs <= '0;                          // pattern, config and counters all start empty
		end else begin
			regs <= regs_next;
		end
	end

	// read mux straight from the storage, so a write shows one cycle after its strobe
	always_comb begin
		rd_data = 8'h00;
		for (int i = 0; i < reg_count; i++) begin
			if (rd_addr == reg_addr_t'(i)) begin
				rd_data = regs[i];
			end
		end
	end

endmodule

/* rtl/signal_generator.sv */
// pattern generator core; accepts trigger edges, shifts the pattern out and builds write-back
`timescale 1ns/100ps

module signal_generator
	import siggen_regmap_pkg::*;
	import siggen_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        trigger,                 // level, already synchronous to clk
	input  logic        tick,                    // timebase step strobe
	input  logic [31:0] timestamp,               // captured on accepted edges
	input  reg_array_t  regs,                    // current register contents
	output reg_flags_t  upd_flags,               // write-back request per byte
	output reg_array_t  upd_data,                // write-back value per byte
	output logic        sig_out,                 // serial pattern output
	output logic        running                  // high from accepted edge to end of sleep
);

	cfg_byte_u   cfg;                            // config byte as flags
	logic        trig_q;                         // trigger one cycle earlier
	gen_state_t  state;
	logic [7:0]  index;                          // pattern bit index, or sleep ticks left - 1
	logic [7:0]  next_index;
	logic [63:0] pattern;                        // bit n is bit n%8 of byte n/8
	logic [7:0]  len_m1;                         // L-1, L=0 read as 64
	logic [7:0]  sleep_m1;                       // S-1, S=0 read as 256
	logic        rise_edge;
	logic        fall_edge;
	logic        can_fire;                       // idle and armed
	logic        fire_rise;                      // accepted rising edge
	logic        fire_fall;                      // accepted falling edge
	logic        fire;
	logic [7:0]  cfg_cleared;                    // config byte after one-shot clearing

	assign cfg.raw    = regs[config_addr];
	assign pattern    = regs[pattern_base +: 8];
	assign len_m1     = {2'b00, regs[length_addr][5:0] - 6'd1}; // 6-bit wrap gives 63 for 0
	assign sleep_m1   = regs[sleep_addr] - 8'd1;               // 0 wraps to 255
	assign next_index = index - 8'd1;

	assign running = (state != st_idle);

	// edge detect and acceptance
	assign rise_edge = trigger & ~trig_q;
	assign fall_edge = ~trigger & trig_q;
	assign can_fire  = ~running & cfg.cfg.enable & (cfg.cfg.loop_mode != mode_off);
	assign fire_rise = can_fire & rise_edge & cfg.cfg.trig_rise;
	assign fire_fall = can_fire & fall_edge & cfg.cfg.trig_fall;
	assign fire      = fire_rise | fire_fall;

	// single mode disarms itself; with both edges armed only the fired one is dropped
	always_comb begin
		cfg_cleared = cfg.raw;                   // multi and loop keep the byte as is
		if (cfg.cfg.loop_mode == mode_single) begin
			if (cfg.cfg.trig_rise & cfg.cfg.trig_fall) begin
				cfg_cleared = fire_rise ? (cfg.raw & clear_rise_mask)
				                        : (cfg.raw & clear_fall_mask);
			end else begin
				cfg_cleared = cfg.raw & clear_single_mask;
			end
		end
	end

	// write-back, stored by the register file in the accepting cycle
	always_comb begin
		upd_flags = '0;                          // untouched bytes never requested
		upd_data  = regs;
		for (int i = 0; i < 4; i++) begin
			upd_data[rise_ts_addr + i]  = timestamp[8*i +: 8];
			upd_data[fall_ts_addr + i]  = timestamp[8*i +: 8];
			upd_flags[rise_ts_addr + i] = fire_rise & cfg.cfg.save_rise;
			upd_flags[fall_ts_addr + i] = fire_fall & cfg.cfg.save_fall;
		end
		upd_data[config_addr]      = cfg_cleared;
		upd_flags[config_addr]     = fire;
		upd_data[trig_count_addr]  = regs[trig_count_addr] + 8'd1; // wraps at 255
		upd_flags[trig_count_addr] = fire;
	end

	// pattern/sleep FSM, one step per tick
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			trig_q  <= 1'b0;
			state   <= st_idle;
			index   <= '0;
			sig_out <= 1'b0;
		end else begin
			trig_q <= trigger;
			if (fire) begin
				state   <= st_pattern;           // msb of the selected length goes out now
				index   <= len_m1;
				sig_out <= pattern[len_m1[5:0]];
			end else if (tick) begin
				case (state)
					st_pattern: begin
						if (index == 8'd0) begin
							state <= st_sleep;   // sig_out keeps bit 0
							index <= sleep_m1;
						end else begin
							index   <= next_index;
							sig_out <= pattern[next_index[5:0]];
						end
					end
					st_sleep: begin
						if (index != 8'd0) begin
							index <= next_index;
						end else if (cfg.cfg.loop_mode == mode_loop) begin
							state   <= st_pattern; // next pass without a trigger
							index   <= len_m1;
							sig_out <= pattern[len_m1[5:0]];
						end else begin
							state <= st_idle;    // single and multi wait here
						end
					end
					default: begin
						state <= st_idle;        // idle, or recovery from the unused code
					end
				endcase
			end
		end
	end

endmodule

/* rtl/siggen_top.sv */
// top of the serial pattern generator; register file, timebase and generator core
`timescale 1ns/100ps

module siggen_top
	import siggen_regmap_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       trigger,                  // start level, synchronous to clk
	input  host_wr_t   host_wr,                  // one-cycle register write
	input  reg_addr_t  rd_addr,                  // combinational register read
	output logic [7:0] rd_data,
	output logic       sig_out,                  // pattern output
	output logic       running                   // a pass is in progress
);

	reg_array_t  regs;                           // register file contents
	reg_flags_t  upd_flags;                      // generator write-back requests
	reg_array_t  upd_data;                       // generator write-back values
	logic        tick;
	logic [31:0] timestamp;

	config_regfile u_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.host_wr   (host_wr),
		.upd_flags (upd_flags),
		.upd_data  (upd_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.regs      (regs)
	);

	timebase u_timebase (
		.clk       (clk),
		.rst_n     (rst_n),
		.regs      (regs),                       // divisor and bypass
		.tick      (tick),
		.timestamp (timestamp)
	);

	signal_generator u_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.trigger   (trigger),
		.tick      (tick),
		.timestamp (timestamp),
		.regs      (regs),
		.upd_flags (upd_flags),
		.upd_data  (upd_data),
		.sig_out   (sig_out),
		.running   (running)
	);

endmodule

/* tests/siggen_assertions.sv */
// concurrent checks on the generator core, bound into every signal_generator instance
`timescale 1ns/100ps

module siggen_assertions
	import siggen_regmap_pkg::*;
	import siggen_ctrl_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input gen_state_t state,
	input logic       running,
	input reg_flags_t upd_flags                   // write-back requests of the core
);

	int fail_count = 0;                           // failed assertions so far

	running_after_reset: assert property (@(posedge clk) !rst_n |=> !running)
		else begin
			$error("running is high in the cycle after reset");
			fail_count++;
		end

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_idle) || (state == st_pattern) || (state == st_sleep))
		else begin
			$error("generator FSM holds the unused state encoding");
			fail_count++;
		end

	// a pass in progress never accepts an edge, so no count write-back
	no_count_while_running: assert property (@(posedge clk) disable iff (!rst_n)
		!(upd_flags[trig_count_addr] && running))
		else begin
			$error("trigger count updated while running");
			fail_count++;
		end

	cfg_with_count: assert property (@(posedge clk) disable iff (!rst_n)
		upd_flags[config_addr] == upd_flags[trig_count_addr])
		else begin
			$error("config and trigger count update flags differ");
			fail_count++;
		end

endmodule

bind signal_generator siggen_assertions u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.state     (state),
	.running   (running),
	.upd_flags (upd_flags)
);

/* tests/siggen_tb.sv */
// testbench of siggen_top; register access, single, multi, loop and divided-tick passes
`timescale 1ns/100ps

module siggen_tb
	import siggen_regmap_pkg::*;
	import siggen_ctrl_pkg::*;
();

	localparam int max_pass       = 64 + 256;                 // longest pass in ticks
	localparam int timeout_cycles = 8 * max_pass + max_pass * 2 * 8 + 1000;

	logic       clk;
	logic       rst_n;
	logic       trigger;
	host_wr_t   host_wr;
	reg_addr_t  rd_addr;
	logic [7:0] rd_data;
	logic       sig_out;
	logic       running;

	logic [31:0] lfsr = 32'h261b_c8a8;                        // random source state
	int          cycle;                                       // follows the DUT timestamp
	int          errors = 0;
	int          checks = 0;
	logic [7:0]  model [reg_count];                           // expected register file
	logic [63:0] cur_pattern;
	int          cur_len;                                     // L, 1..64
	int          cur_sleep;                                   // S, 1..256
	int          cmp_start = 0;                               // first compared cycle
	int          cmp_end = -1;                                // last compared cycle
	bit          cmp_loop = 1'b0;

	siggen_top uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.trigger (trigger),
		.host_wr (host_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.sig_out (sig_out),
		.running (running)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst_n) cycle <= 0;
		else cycle <= cycle + 1;
	end

	always @(negedge clk) begin
		if (cycle > timeout_cycles) begin
			$display("run timed out after %0d cycles without finishing the tests", cycle);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);      // x^32+x^22+x^2+x+1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};                            // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// expected sig_out k ticks after the accepting edge
	function automatic logic ref_sig(input logic [63:0] pat, input int len, input int k);
		logic [63:0] shifted;
		if (k < len) shifted = pat >> (len - 1 - k);
		else shifted = pat;                                       // sleep holds bit 0
		return shifted[0];
	endfunction

	function automatic logic [7:0] make_cfg(input loop_mode_t mode, input bit rise,
		input bit fall, input bit save_r, input bit save_f, input bit bypass);
		sig_cfg_t c;
		c.save_fall  = save_f;
		c.save_rise  = save_r;
		c.loop_mode  = mode;
		c.trig_fall  = fall;
		c.trig_rise  = rise;
		c.div_bypass = bypass;
		c.enable     = 1'b1;
		return c;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic write_reg(input int addr, input logic [7:0] data);
		@(negedge clk);
		host_wr.en   = 1'b1;
		host_wr.addr = reg_addr_t'(addr);
		host_wr.data = data;
		model[addr]  = data;
		@(negedge clk);
		host_wr.en = 1'b0;                                        // one-cycle strobe
	endtask

	task automatic read_reg(input int addr, output logic [7:0] data);
		@(negedge clk);
		rd_addr = reg_addr_t'(addr);
		#1;
		data = rd_data;
	endtask

	task automatic check_all_regs();
		logic [7:0] v;
		for (int i = 0; i < reg_count; i++) begin
			read_reg(i, v);
			check_value($sformatf("reg[%0d]", i), 32'(v), 32'(model[i]));
		end
	endtask

	// register write-back expected from one accepted edge
	task automatic model_fire(input bit rise, input int ts);
		sig_cfg_t c;
		c = model[config_addr];
		model[trig_count_addr] = model[trig_count_addr] + 8'd1;
		for (int b = 0; b < 4; b++) begin
			if (rise && c.save_rise) model[rise_ts_addr + b] = 8'(ts >> (8 * b));
			if (!rise && c.save_fall) model[fall_ts_addr + b] = 8'(ts >> (8 * b));
		end
		if (c.loop_mode == mode_single) begin
			if (c.trig_rise && c.trig_fall) begin
				if (rise) c.trig_rise = 1'b0;                     // other edge stays armed
				else c.trig_fall = 1'b0;
			end else begin
				c.enable    = 1'b0;
				c.trig_rise = 1'b0;
				c.trig_fall = 1'b0;
			end
		end
		model[config_addr] = c;
	endtask

	task automatic load_random_pattern();
		logic [31:0] r;
		for (int b = 0; b < 8; b++) begin
			take_bits(8, r);
			write_reg(pattern_base + b, r[7:0]);
			cur_pattern[8 * b +: 8] = r[7:0];
		end
		take_bits(6, r);
		write_reg(length_addr, {2'b00, r[5:0]});
		cur_len = (r[5:0] == 6'd0) ? 64 : int'(r[5:0]);
		take_bits(8, r);
		write_reg(sleep_addr, r[7:0]);
		cur_sleep = (r[7:0] == 8'd0) ? 256 : int'(r[7:0]);
	endtask

	// drives one trigger level and opens the compare window behind it
	task automatic fire_edge(input logic level, input bit windowed, input bit loop,
		input int passes, output int ts);
		@(negedge clk);
		trigger   = level;
		ts        = cycle;                                        // timestamp seen at the edge
		cmp_loop  = loop;
		cmp_start = cycle + 1;
		if (!windowed) cmp_end = cmp_start - 1;
		else if (loop) cmp_end = cmp_start + passes * (cur_len + cur_sleep) - 1;
		else cmp_end = cmp_start + cur_len + cur_sleep;           // includes running falling
	endtask

	task automatic wait_window();
		while (cycle <= cmp_end) @(negedge clk);
	endtask

	// compare process for bypass runs, one sample per cycle
	always @(negedge clk) begin : compare_outputs
		int k;
		int plen;
		if (rst_n && cycle >= cmp_start && cycle <= cmp_end) begin
			k    = cycle - cmp_start;
			plen = cur_len + cur_sleep;
			if (cmp_loop) begin
				check_value("sig_out", 32'(sig_out), 32'(ref_sig(cur_pattern, cur_len, k % plen)));
				check_value("running", 32'(running), 32'd1);
			end else begin
				check_value("sig_out", 32'(sig_out), 32'(ref_sig(cur_pattern, cur_len, k)));
				check_value("running", 32'(running), (k < plen) ? 32'd1 : 32'd0);
			end
		end
	end

	task automatic run_divided();
		logic [31:0] r;
		int          div;
		int          ts;
		int          run_cycles;
		int          lo;
		int          hi;
		logic        got_seq[$];                                  // sig_out with repeats removed
		logic        exp_seq[$];
		load_random_pattern();
		take_bits(3, r);
		div = int'(r[2:0]);                                       // small D keeps the pass short
		write_reg(divisor_addr, 8'(div));
		write_reg(config_addr, make_cfg(mode_multi, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
		@(negedge clk);
		trigger = 1'b0;
		fire_edge(1'b1, 1'b0, 1'b0, 1, ts);
		model_fire(1'b1, ts);
		run_cycles = 0;
		@(negedge clk);
		while (running) begin
			run_cycles++;
			if (got_seq.size() == 0 || got_seq[$] != sig_out) got_seq.push_back(sig_out);
			@(negedge clk);
		end
		for (int k = 0; k < cur_len; k++) begin
			if (exp_seq.size() == 0 || exp_seq[$] != ref_sig(cur_pattern, cur_len, k))
				exp_seq.push_back(ref_sig(cur_pattern, cur_len, k));
		end
		check_value("sig_out value count", 32'(got_seq.size()), 32'(exp_seq.size()));
		for (int i = 0; i < got_seq.size() && i < exp_seq.size(); i++)
			check_value("sig_out value", 32'(got_seq[i]), 32'(exp_seq[i]));
		lo = (cur_len + cur_sleep - 1) * 2 * (div + 1);
		hi = (cur_len + cur_sleep) * 2 * (div + 1);
		checks++;
		if (run_cycles < lo || run_cycles > hi) begin
			errors++;
			$display("running lasted %0d cycles, outside the range %0d to %0d", run_cycles, lo, hi);
		end
		check_all_regs();
	endtask

	initial begin : stimulus
		int          ts;
		logic [31:0] r;
		logic [7:0]  v;
		rst_n   = 1'b0;
		trigger = 1'b0;
		host_wr = '0;
		rd_addr = '0;
		for (int i = 0; i < reg_count; i++) model[i] = 8'h00;   // file is cleared by reset
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// random bytes into every register, then read back
		for (int i = 0; i < reg_count; i++) begin
			take_bits(8, r);
			write_reg(i, r[7:0]);
		end
		check_all_regs();
		read_reg(reg_count, v);
		check_value("rd_data past last register", 32'(v), 32'd0);
		write_reg(divisor_addr, 8'h00);                           // divider reloads every cycle

		// single mode on a rising edge, then a second edge that must be ignored
		load_random_pattern();
		write_reg(config_addr, make_cfg(mode_single, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1));
		fire_edge(1'b1, 1'b1, 1'b0, 1, ts);
		model_fire(1'b1, ts);
		wait_window();
		check_all_regs();
		@(negedge clk);
		trigger = 1'b0;
		@(negedge clk);
		trigger = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_value("running", 32'(running), 32'd0);
		end
		check_all_regs();

		// single mode with both edges armed, fired by the falling one
		load_random_pattern();
		write_reg(config_addr, make_cfg(mode_single, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
		fire_edge(1'b0, 1'b1, 1'b0, 1, ts);
		model_fire(1'b0, ts);
		wait_window();
		check_all_regs();

		// multi mode, edges during the pass change nothing
		load_random_pattern();
		write_reg(config_addr, make_cfg(mode_multi, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
		fire_edge(1'b1, 1'b1, 1'b0, 1, ts);
		model_fire(1'b1, ts);
		@(negedge clk);
		trigger = 1'b0;
		@(negedge clk);
		trigger = 1'b1;                                           // rising edge while running
		wait_window();
		check_all_regs();
		@(negedge clk);
		trigger = 1'b0;
		fire_edge(1'b1, 1'b1, 1'b0, 1, ts);
		model_fire(1'b1, ts);
		wait_window();
		check_all_regs();

		// loop mode, three passes back to back
		load_random_pattern();
		write_reg(config_addr, make_cfg(mode_loop, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
		@(negedge clk);
		trigger = 1'b0;
		fire_edge(1'b1, 1'b1, 1'b1, 3, ts);
		model_fire(1'b1, ts);
		wait_window();
		write_reg(config_addr, make_cfg(mode_off, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
		while (running) @(negedge clk);                           // current pass runs out
		check_all_regs();

		// divided timebase
		run_divided();

		errors = errors + uut.u_gen.u_assert.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
rtl/siggen_regmap_pkg.sv
rtl/siggen_ctrl_pkg.sv
rtl/timebase.sv
rtl/config_regfile.sv
rtl/signal_generator.sv
rtl/siggen_top.sv
tests/siggen_assertions.sv
tests/siggen_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the pattern generator testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module siggen_tb -f all.f -o siggen_sim

# keep running past the first assertion failure so the testbench reaches its result line
./obj_dir/siggen_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
